//--- include/id_defines.svh
// decode stage sizing constants and fixed instruction encodings
`ifndef ID_DEFINES_SVH
`define ID_DEFINES_SVH

// log2 of slots per fetch buffer bank
`define ID_BUF_AW 3

// free slots per bank below which full is raised
// the fetch side cannot stall in the same cycle, so keep room for in-flight pairs
`define ID_FULL_MARGIN 3

`define ID_INST_W 32

// addi.w r0,r0,0
`define ID_INST_NOP 32'h0280_0000

`endif

//--- source/id_uop_pkg.sv
// decoded side types: operation codes, branch classes, exception codes, micro-op
package id_uop_pkg;

    typedef enum logic [4:0] {
        OP_NONE,        // empty slot or illegal word
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_ADDI,
        OP_LU12I,
        OP_LD,
        OP_ST,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_B,
        OP_BL,
        OP_JIRL,
        OP_SYSCALL,
        OP_BREAK,
        OP_ERTN
    } op_e;

    // same encoding the predictor stores in its record
    typedef enum logic [1:0] {
        CAT_NONE     = 2'b00,
        CAT_COND     = 2'b01,
        CAT_DIRECT   = 2'b10,   // b, bl
        CAT_INDIRECT = 2'b11    // jirl
    } category_e;

    typedef enum logic [6:0] {
        EXC_NONE = 7'h00,
        EXC_ADEF = 7'h08,   // fetch address fault
        EXC_SYS  = 7'h0b,
        EXC_BRK  = 7'h0c,
        EXC_INE  = 7'h0d,
        EXC_IPE  = 7'h0e
    } exc_e;

    typedef struct packed {
        logic        valid;
        op_e         op;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [31:0] imm;
        logic [31:0] pc;
        logic [31:0] pc_next;
        exc_e        exc;
        logic [31:0] badv;
        logic        unknown;   // predictor had no record of this one
    } uop_t;

endpackage

//--- source/id_fetch_pkg.sv
// fetch side types: incoming fetch pair, fetch buffer entry, pc redirect
`include "id_defines.svh"

package id_fetch_pkg;

    typedef struct packed {
        logic [`ID_INST_W-1:0] inst0;
        logic [`ID_INST_W-1:0] inst1;
        logic [31:0]           pc;          // pc of inst0, bit 2 set means inst0 absent
        logic [31:0]           pc_next;     // predicted next fetch pc
        id_uop_pkg::exc_e      exc;
        logic [31:0]           badv;
        logic                  unknown0;
        logic                  unknown1;
        logic [31:0]           pred_record0; // {target[31:2], category}
        logic [31:0]           pred_record1;
        logic                  first_inst_jmp;
    } fetch_bundle_t;

    typedef struct packed {
        logic [`ID_INST_W-1:0] inst;
        logic [31:0]           pc;
        logic [31:0]           pc_next;
        id_uop_pkg::exc_e      exc;
        logic [31:0]           badv;
        logic                  unknown;
    } buf_entry_t;

    typedef struct packed {
        logic        set_pc;
        logic [31:0] target;
    } redirect_t;

endpackage

//--- source/id_predecoder.sv
// branch predecoder: classifies one word and extracts its pc-relative offset
`timescale 1ns/1ps
`include "id_defines.svh"

module id_predecoder (
    input  logic [`ID_INST_W-1:0]  inst,
    output id_uop_pkg::category_e  category,
    output logic [31:0]            pc_offset
);

    logic [31:0] offs16;
    logic [31:0] offs26;

    assign offs16 = {{14{inst[25]}}, inst[25:10], 2'b00};
    assign offs26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};   // high half sits low

    always_comb begin
        category  = id_uop_pkg::CAT_NONE;
        pc_offset = '0;
        case (inst[31:26])
            6'b010011: begin    // jirl, offset is rj relative
                category  = id_uop_pkg::CAT_INDIRECT;
                pc_offset = offs16;
            end
            6'b010100, 6'b010101: begin     // b, bl
                category  = id_uop_pkg::CAT_DIRECT;
                pc_offset = offs26;
            end
            6'b010110, 6'b010111, 6'b011000: begin  // beq, bne, blt
                category  = id_uop_pkg::CAT_COND;
                pc_offset = offs16;
            end
            default: ;
        endcase
    end

endmodule

//--- source/id_redirect_check.sv
// static branch check on the fetch pair, raises pc redirects and packs entries to push
`timescale 1ns/1ps

module id_redirect_check (
    input  logic                        input_valid,
    input  id_fetch_pkg::fetch_bundle_t fetch,
    output id_fetch_pkg::redirect_t     redirect,
    output logic [1:0]                  push_valid,
    output id_fetch_pkg::buf_entry_t    push_entry0,
    output id_fetch_pkg::buf_entry_t    push_entry1
);

    id_uop_pkg::category_e cat0, cat1;
    logic [31:0] offset0, offset1;
    logic [31:0] pc0, pc1;
    logic [31:0] target0, target1;
    logic [31:0] static_next0, static_next1;
    logic [31:0] pred_next0, pred_next1;
    logic        unknown0, unknown1;
    logic        slot0_ok, slot1_ok;
    logic        redir0, redir1;
    logic        valid0, valid1;
    id_fetch_pkg::buf_entry_t entry0, entry1;

    id_predecoder u_predec0 (.inst(fetch.inst0), .category(cat0), .pc_offset(offset0));
    id_predecoder u_predec1 (.inst(fetch.inst1), .category(cat1), .pc_offset(offset1));

    assign slot0_ok = input_valid && !fetch.pc[2];
    assign slot1_ok = input_valid && !fetch.first_inst_jmp;

    assign pc0 = fetch.pc;
    assign pc1 = fetch.pc[2] ? fetch.pc : fetch.pc + 32'd4;
    assign target0 = pc0 + offset0;
    assign target1 = pc1 + offset1;

    // static rule: always jump for b/bl, backward conditionals taken
    assign static_next0 = (cat0 == id_uop_pkg::CAT_DIRECT ||
                           (cat0 == id_uop_pkg::CAT_COND && offset0[31])) ? target0 : pc0 + 32'd4;
    assign static_next1 = (cat1 == id_uop_pkg::CAT_DIRECT ||
                           (cat1 == id_uop_pkg::CAT_COND && offset1[31])) ? target1 : pc1 + 32'd4;

    assign pred_next0 = fetch.first_inst_jmp ? fetch.pc_next : pc0 + 32'd4;
    assign pred_next1 = fetch.pc_next;

    assign unknown0 = fetch.unknown0 || fetch.pred_record0 != {target0[31:2], cat0};
    assign unknown1 = fetch.unknown1 || fetch.pred_record1 != {target1[31:2], cat1};

    // slot 0 wins, and a slot 0 redirect kills slot 1
    assign redir0 = slot0_ok && unknown0 && pred_next0 != static_next0;
    assign redir1 = slot1_ok && !redir0 && unknown1 && pred_next1 != static_next1;

    assign redirect.set_pc = redir0 || redir1;
    assign redirect.target = redir0 ? static_next0 : static_next1;

    assign valid0 = slot0_ok;
    assign valid1 = slot1_ok && !redir0;

    assign entry0 = '{inst: fetch.inst0, pc: pc0,
                      pc_next: redir0 ? static_next0 : pred_next0,
                      exc: fetch.exc, badv: fetch.badv, unknown: fetch.unknown0};
    assign entry1 = '{inst: fetch.inst1, pc: pc1,
                      pc_next: redir1 ? static_next1 : pred_next1,
                      exc: fetch.exc, badv: fetch.badv, unknown: fetch.unknown1};

    // first valid slot always goes out on entry0
    assign push_valid  = {valid0 && valid1, valid0 || valid1};
    assign push_entry0 = valid0 ? entry0 : entry1;
    assign push_entry1 = entry1;

endmodule

//--- source/id_fetch_buffer.sv
// two-bank interleaved fetch buffer, up to two pushes and two pops per cycle
`timescale 1ns/1ps
`include "id_defines.svh"

module id_fetch_buffer #(
    parameter type entry_t = id_fetch_pkg::buf_entry_t
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       flush,
    input  logic [1:0] push_valid,
    input  entry_t     push_entry0,
    input  entry_t     push_entry1,
    input  logic [1:0] read_en,     // 01 pops one, 11 pops two
    output logic       full,
    output logic [1:0] head_valid,
    output entry_t     head_entry0,
    output entry_t     head_entry1
);

    localparam int DEPTH = 1 << `ID_BUF_AW;

    entry_t bank0 [DEPTH];
    entry_t bank1 [DEPTH];

    logic [`ID_BUF_AW-1:0] head0, head1, tail0, tail1;
    logic [`ID_BUF_AW-1:0] free0, free1;
    logic push_sel;     // bank taking the next single push
    logic pop_sel;      // bank holding the oldest entry
    logic empty0, empty1;
    logic really_full;
    logic push_one, push_both;
    logic do_push0, do_push1, do_pop0, do_pop1;

    // one slot per bank stays unused to tell full from empty
    assign free0  = head0 - tail0 - 1'b1;
    assign free1  = head1 - tail1 - 1'b1;
    assign empty0 = head0 == tail0;
    assign empty1 = head1 == tail1;

    assign really_full = free0 == '0 || free1 == '0;
    assign full        = free0 < `ID_FULL_MARGIN || free1 < `ID_FULL_MARGIN;

    assign push_one  = push_valid == 2'b01;
    assign push_both = push_valid == 2'b11;

    assign do_push0 = !really_full && (push_both || (push_one && !push_sel));
    assign do_push1 = !really_full && (push_both || (push_one && push_sel));
    assign do_pop0  = !empty0 && (read_en[1] || (read_en[0] && !pop_sel));
    assign do_pop1  = !empty1 && (read_en[1] || (read_en[0] && pop_sel));

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            head0    <= '0;
            head1    <= '0;
            tail0    <= '0;
            tail1    <= '0;
            push_sel <= 1'b0;
            pop_sel  <= 1'b0;
        end else begin
            if (do_push0) tail0 <= tail0 + 1'b1;
            if (do_push1) tail1 <= tail1 + 1'b1;
            if (do_pop0) head0 <= head0 + 1'b1;
            if (do_pop1) head1 <= head1 + 1'b1;
            if (push_one && !really_full) push_sel <= !push_sel;
            if (do_pop0 ^ do_pop1) pop_sel <= !pop_sel;   // odd count moves the oldest bank
        end
    end

    always_ff @(posedge clk) begin
        if (do_push0) bank0[tail0] <= push_sel ? push_entry1 : push_entry0;
        if (do_push1) bank1[tail1] <= push_sel ? push_entry0 : push_entry1;
    end

    assign head_valid  = pop_sel ? {!empty0, !empty1} : {!empty1, !empty0};
    assign head_entry0 = pop_sel ? bank1[head1] : bank0[head0];
    assign head_entry1 = pop_sel ? bank0[head0] : bank1[head1];

    a_read_en_legal: assert property (@(posedge clk) disable iff (!rst_n) read_en != 2'b10)
        else $error("read_en 10 is not a legal pop request");

    // fetch side should have stopped on full before a bank runs out
    a_no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n || flush)
        (|push_valid) |-> !really_full)
        else $error("push into a full fetch buffer bank dropped");

endmodule

//--- source/id_decoder.sv
// instruction decoder: one buffer entry to a micro-op with fields, immediate and exception
`timescale 1ns/1ps
`include "id_defines.svh"

module id_decoder (
    input  logic                     entry_valid,
    input  id_fetch_pkg::buf_entry_t entry,
    input  logic [1:0]               plv,
    output id_uop_pkg::uop_t         uop
);

    logic [`ID_INST_W-1:0] inst;
    id_uop_pkg::op_e       op;
    logic [31:0]           imm;
    logic                  illegal;
    logic [31:0]           si12, ui20, offs16, offs26;

    // empty bank decodes as a nop
    assign inst = entry_valid ? entry.inst : `ID_INST_NOP;

    assign si12   = {{20{inst[21]}}, inst[21:10]};
    assign ui20   = {inst[24:5], 12'h000};
    assign offs16 = {{14{inst[25]}}, inst[25:10], 2'b00};
    assign offs26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};

    always_comb begin
        op      = id_uop_pkg::OP_NONE;
        imm     = '0;
        illegal = 1'b0;
        if (inst == 32'h0648_3800) begin
            op = id_uop_pkg::OP_ERTN;
        end else if (inst[31:15] == 17'h00020) begin
            op = id_uop_pkg::OP_ADD;
        end else if (inst[31:15] == 17'h00022) begin
            op = id_uop_pkg::OP_SUB;
        end else if (inst[31:15] == 17'h00029) begin
            op = id_uop_pkg::OP_AND;
        end else if (inst[31:15] == 17'h0002a) begin
            op = id_uop_pkg::OP_OR;
        end else if (inst[31:15] == 17'h00054) begin
            op = id_uop_pkg::OP_BREAK;
        end else if (inst[31:15] == 17'h00056) begin
            op = id_uop_pkg::OP_SYSCALL;
        end else if (inst[31:22] == 10'h00a) begin
            op  = id_uop_pkg::OP_ADDI;
            imm = si12;
        end else if (inst[31:22] == 10'h0a2) begin
            op  = id_uop_pkg::OP_LD;
            imm = si12;
        end else if (inst[31:22] == 10'h0a6) begin
            op  = id_uop_pkg::OP_ST;
            imm = si12;
        end else if (inst[31:25] == 7'b0001010) begin
            op  = id_uop_pkg::OP_LU12I;
            imm = ui20;
        end else begin
            imm = offs16;   // branch offsets, overridden below for b/bl
            case (inst[31:26])
                6'b010011: op = id_uop_pkg::OP_JIRL;
                6'b010110: op = id_uop_pkg::OP_BEQ;
                6'b010111: op = id_uop_pkg::OP_BNE;
                6'b011000: op = id_uop_pkg::OP_BLT;
                6'b010100: begin
                    op  = id_uop_pkg::OP_B;
                    imm = offs26;
                end
                6'b010101: begin
                    op  = id_uop_pkg::OP_BL;
                    imm = offs26;
                end
                default: begin
                    imm     = '0;
                    illegal = 1'b1;
                end
            endcase
        end
    end

    always_comb begin
        uop.valid   = entry_valid;
        uop.op      = entry_valid ? op : id_uop_pkg::OP_NONE;
        uop.rd      = inst[4:0];
        uop.rj      = inst[9:5];
        uop.rk      = inst[14:10];
        uop.imm     = imm;
        uop.pc      = entry_valid ? entry.pc : 32'd0;
        uop.pc_next = entry_valid ? entry.pc_next : 32'd4;
        uop.badv    = entry_valid ? entry.badv : 32'd0;
        uop.unknown = entry_valid && entry.unknown;
        // b and bl reuse the rd bits for offset, bl links to r1
        if (op == id_uop_pkg::OP_B) uop.rd = 5'd0;
        if (op == id_uop_pkg::OP_BL) uop.rd = 5'd1;

        if (!entry_valid)
            uop.exc = id_uop_pkg::EXC_NONE;
        else if (entry.exc != id_uop_pkg::EXC_NONE)
            uop.exc = entry.exc;   // fetch fault has priority
        else if (illegal)
            uop.exc = id_uop_pkg::EXC_INE;
        else if (op == id_uop_pkg::OP_SYSCALL)
            uop.exc = id_uop_pkg::EXC_SYS;
        else if (op == id_uop_pkg::OP_BREAK)
            uop.exc = id_uop_pkg::EXC_BRK;
        else if (op == id_uop_pkg::OP_ERTN && plv != 2'd0)
            uop.exc = id_uop_pkg::EXC_IPE;
        else
            uop.exc = id_uop_pkg::EXC_NONE;
    end

endmodule

//--- source/id_stage.sv
// decode stage top: redirect check, fetch buffer and two decoders
`timescale 1ns/1ps

module id_stage (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        input_valid,
    input  id_fetch_pkg::fetch_bundle_t fetch,
    input  logic                        flush,
    input  logic [1:0]                  read_en,
    input  logic [1:0]                  plv,
    output logic                        full,
    output id_fetch_pkg::redirect_t     redirect,
    output id_uop_pkg::uop_t            uop0,
    output id_uop_pkg::uop_t            uop1
);

    logic [1:0]               push_valid;
    id_fetch_pkg::buf_entry_t push_entry0, push_entry1;
    logic [1:0]               head_valid;
    id_fetch_pkg::buf_entry_t head_entry0, head_entry1;

    id_redirect_check u_redirect_check (
        .input_valid (input_valid),
        .fetch       (fetch),
        .redirect    (redirect),
        .push_valid  (push_valid),
        .push_entry0 (push_entry0),
        .push_entry1 (push_entry1)
    );

    id_fetch_buffer #(.entry_t(id_fetch_pkg::buf_entry_t)) u_fetch_buffer (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .push_valid  (push_valid),
        .push_entry0 (push_entry0),
        .push_entry1 (push_entry1),
        .read_en     (read_en),
        .full        (full),
        .head_valid  (head_valid),
        .head_entry0 (head_entry0),
        .head_entry1 (head_entry1)
    );

    id_decoder u_decoder0 (.entry_valid(head_valid[0]), .entry(head_entry0), .plv(plv), .uop(uop0));
    id_decoder u_decoder1 (.entry_valid(head_valid[1]), .entry(head_entry1), .plv(plv), .uop(uop1));

endmodule

//--- testbench/tb_clock_gen.sv
// testbench clock and reset source, 4 ns period with reset held for 3 cycles
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;   // released on the third rising edge
    end

endmodule

//--- testbench/tb_id_checker.sv
// result checker for the decode stage, compares DUT outputs and keeps the counts
`timescale 1ns/1ps

module tb_id_checker (
    input logic                    full,
    input id_fetch_pkg::redirect_t redirect,
    input id_uop_pkg::uop_t        uop0,
    input id_uop_pkg::uop_t        uop1
);

    localparam int W = 160;   // wide enough for a whole uop

    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int mismatches = 0;

    task automatic compare(input string name, input string what,
                           input logic [W-1:0] exp, input logic [W-1:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED %s %s expected %h actual %h", name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_redirect(input string name, input id_fetch_pkg::redirect_t exp);
        compare(name, "set_pc", W'(exp.set_pc), W'(redirect.set_pc));
        if (exp.set_pc)
            compare(name, "target", W'(exp.target), W'(redirect.target));
    endtask

    task automatic check_uops(input string name,
                              input id_uop_pkg::uop_t e0, input id_uop_pkg::uop_t e1);
        compare(name, "uop0", W'(e0), W'(uop0));
        compare(name, "uop1", W'(e1), W'(uop1));
    endtask

    task automatic check_full(input string name, input logic exp);
        compare(name, "full", W'(exp), W'(full));
    endtask

    // oldest two entries by pc
    task automatic check_head_pc(input string name, input logic [31:0] pc0,
                                 input logic [31:0] pc1);
        compare(name, "uop0.valid", W'(1'b1), W'(uop0.valid));
        compare(name, "uop0.pc", W'(pc0), W'(uop0.pc));
        compare(name, "uop1.pc", W'(pc1), W'(uop1.pc));
    endtask

    task automatic check_empty(input string name);
        compare(name, "uop0.valid", W'(1'b0), W'(uop0.valid));
        compare(name, "uop1.valid", W'(1'b0), W'(uop1.valid));
        compare(name, "full", W'(1'b0), W'(full));
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != 0) begin
            tests_failed++;
            $display("%s: %0d mismatches", name, errors);
        end else begin
            $display("%s: ok", name);
        end
        mismatches += errors;
        errors = 0;
    endtask

    task automatic summary();
        $display("tests run %0d, failed %0d, mismatches %0d", tests_run, tests_failed, mismatches);
    endtask

endmodule

//--- testbench/tb_id_stage.sv
// table driven testbench top for the decode stage with a watchdog
`timescale 1ns/1ps
`include "id_defines.svh"

module tb_id_stage;

    typedef id_fetch_pkg::fetch_bundle_t fetch_t;
    typedef id_fetch_pkg::redirect_t     redir_t;
    typedef id_uop_pkg::uop_t            uop_t;

    typedef struct packed {
        fetch_t     fetch;
        logic [1:0] plv;
        logic [1:0] read_en;
        redir_t     redirect;
        uop_t       uop0;
        uop_t       uop1;
    } vec_t;

    localparam logic [31:0] NOP  = `ID_INST_NOP;
    localparam logic [31:0] ILL  = 32'hffff_ffff;
    localparam logic [31:0] SYSC = 32'h002b_0000;
    localparam logic [31:0] BRK  = 32'h002a_0000;
    localparam logic [31:0] ERTN = 32'h0648_3800;
    localparam logic [31:0] BASE = 32'h1c00_1000;   // start of the fill sequence

    logic       clk, rst_n, input_valid, flush, full;
    logic [1:0] read_en, plv;
    fetch_t     fetch;
    redir_t     redirect;
    uop_t       uop0, uop1;

    logic [31:0] lfsr = 32'h92d2_c129;
    vec_t        table_q[$];
    string       name_q[$];
    logic        table_ready = 1'b0;

    logic [4:0]  rd, rj, rk;
    logic [11:0] si12;
    logic [19:0] si20;
    logic [31:0] i0, i1, pc;
    fetch_t      f;
    uop_t        u0, u1;

    tb_clock_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

    id_stage u_dut (.*);

    tb_id_checker u_checker (.full(full), .redirect(redirect), .uop0(uop0), .uop1(uop1));

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
        end
        return r;
    endfunction

    function automatic fetch_t make_fetch(input logic [31:0] a, input logic [31:0] b,
                                          input logic [31:0] p, input logic [31:0] pn);
        fetch_t x;
        x         = '0;
        x.inst0   = a;
        x.inst1   = b;
        x.pc      = p;
        x.pc_next = pn;
        x.exc     = id_uop_pkg::EXC_NONE;
        return x;
    endfunction

    // register fields straight from the encoding
    function automatic uop_t uop_ok(input logic [31:0] inst, input id_uop_pkg::op_e op,
                                    input logic [31:0] imm, input logic [31:0] p,
                                    input logic [31:0] pn);
        uop_t u;
        u         = '0;
        u.valid   = 1'b1;
        u.op      = op;
        u.rd      = inst[4:0];
        u.rj      = inst[9:5];
        u.rk      = inst[14:10];
        u.imm     = imm;
        u.pc      = p;
        u.pc_next = pn;
        u.exc     = id_uop_pkg::EXC_NONE;
        return u;
    endfunction

    function automatic uop_t no_uop();
        uop_t u;
        u         = '0;
        u.op      = id_uop_pkg::OP_NONE;
        u.exc     = id_uop_pkg::EXC_NONE;
        u.pc_next = 32'd4;
        return u;
    endfunction

    task automatic add_row(input string name, input fetch_t fb, input logic [1:0] lvl,
                           input logic set, input logic [31:0] tgt, input uop_t a,
                           input uop_t b);
        vec_t v;
        v.fetch           = fb;
        v.plv             = lvl;
        v.read_en         = 2'b11;   // drain both after the check
        v.redirect.set_pc = set;
        v.redirect.target = tgt;
        v.uop0            = a;
        v.uop1            = b;
        table_q.push_back(v);
        name_q.push_back(name);
    endtask

    initial begin
        input_valid = 1'b0;
        flush       = 1'b0;
        read_en     = 2'b00;
        plv         = 2'd0;
        fetch       = '0;

        rd = 5'(rand_bits(5));
        rj = 5'(rand_bits(5));
        rk = 5'(rand_bits(5));
        si12 = 12'(rand_bits(12));
        pc = 32'h1c00_0100;
        i0 = {17'h00020, rk, rj, rd};
        i1 = {10'h00a, si12, rk, rd};
        add_row("alu_add_addi", make_fetch(i0, i1, pc, pc + 8), 2'd0, 1'b0, 32'd0,
                uop_ok(i0, id_uop_pkg::OP_ADD, 32'd0, pc, pc + 4),
                uop_ok(i1, id_uop_pkg::OP_ADDI, {{20{si12[11]}}, si12}, pc + 4, pc + 8));

        rd = 5'(rand_bits(5));
        rj = 5'(rand_bits(5));
        si12 = 12'(rand_bits(12));
        si20 = 20'(rand_bits(20));
        pc = 32'h1c00_0180;
        i0 = {7'b0001010, si20, rd};
        i1 = {10'h0a2, si12, rj, rd};
        add_row("mem_lu12i_ld", make_fetch(i0, i1, pc, pc + 8), 2'd0, 1'b0, 32'd0,
                uop_ok(i0, id_uop_pkg::OP_LU12I, {si20, 12'h000}, pc, pc + 4),
                uop_ok(i1, id_uop_pkg::OP_LD, {{20{si12[11]}}, si12}, pc + 4, pc + 8));

        // beq back by 16 bytes
        pc = 32'h1c00_0200;
        i0 = {6'b010110, 16'hfffc, 5'd4, 5'd5};
        f = make_fetch(i0, NOP, pc, pc + 8);
        f.unknown0 = 1'b1;
        u0 = uop_ok(i0, id_uop_pkg::OP_BEQ, 32'hffff_fff0, pc, pc - 16);
        u0.unknown = 1'b1;
        add_row("beq_backward_redirect", f, 2'd0, 1'b1, pc - 16, u0, no_uop());

        pc = 32'h1c00_0300;
        f = make_fetch(i0, NOP, pc, pc + 8);
        i1 = pc - 16;
        f.pred_record0 = {i1[31:2], 2'b01};   // record agrees with target and class
        add_row("beq_record_match", f, 2'd0, 1'b0, 32'd0,
                uop_ok(i0, id_uop_pkg::OP_BEQ, 32'hffff_fff0, pc, pc + 4),
                uop_ok(NOP, id_uop_pkg::OP_ADDI, 32'd0, pc + 4, pc + 8));

        pc = 32'h1c00_0400;
        i0 = {6'b010110, 16'h0004, 5'd4, 5'd5};
        f = make_fetch(i0, NOP, pc, pc + 8);
        f.unknown0 = 1'b1;
        u0 = uop_ok(i0, id_uop_pkg::OP_BEQ, 32'd16, pc, pc + 4);
        u0.unknown = 1'b1;
        add_row("beq_forward", f, 2'd0, 1'b0, 32'd0, u0,
                uop_ok(NOP, id_uop_pkg::OP_ADDI, 32'd0, pc + 4, pc + 8));

        si12 = 12'(rand_bits(12));
        pc = 32'h1c00_0504;
        i1 = {10'h0a6, si12, rj, rd};
        add_row("pc_bit2_st_only", make_fetch(ILL, i1, pc, pc + 4), 2'd0, 1'b0, 32'd0,
                uop_ok(i1, id_uop_pkg::OP_ST, {{20{si12[11]}}, si12}, pc, pc + 4), no_uop());

        pc = 32'h1c00_0600;
        f = make_fetch(NOP, i1, pc, 32'h1c00_0800);
        f.first_inst_jmp = 1'b1;
        f.pred_record0 = pc;
        add_row("first_inst_jmp", f, 2'd0, 1'b0, 32'd0,
                uop_ok(NOP, id_uop_pkg::OP_ADDI, 32'd0, pc, 32'h1c00_0800), no_uop());

        pc = 32'h1c00_0700;
        u0 = uop_ok(ILL, id_uop_pkg::OP_NONE, 32'd0, pc, pc + 4);
        u0.exc = id_uop_pkg::EXC_INE;
        u1 = uop_ok(SYSC, id_uop_pkg::OP_SYSCALL, 32'd0, pc + 4, pc + 8);
        u1.exc = id_uop_pkg::EXC_SYS;
        add_row("illegal_syscall", make_fetch(ILL, SYSC, pc, pc + 8), 2'd0, 1'b0, 32'd0, u0, u1);

        pc = 32'h1c00_0780;
        u0 = uop_ok(ERTN, id_uop_pkg::OP_ERTN, 32'd0, pc, pc + 4);
        u0.exc = id_uop_pkg::EXC_IPE;
        u1 = uop_ok(BRK, id_uop_pkg::OP_BREAK, 32'd0, pc + 4, pc + 8);
        u1.exc = id_uop_pkg::EXC_BRK;
        add_row("ertn_plv3_break", make_fetch(ERTN, BRK, pc, pc + 8), 2'd3, 1'b0, 32'd0, u0, u1);

        add_row("ertn_plv0", make_fetch(ERTN, NOP, pc, pc + 8), 2'd0, 1'b0, 32'd0,
                uop_ok(ERTN, id_uop_pkg::OP_ERTN, 32'd0, pc, pc + 4),
                uop_ok(NOP, id_uop_pkg::OP_ADDI, 32'd0, pc + 4, pc + 8));

        pc = 32'h1c00_0800;
        f = make_fetch(SYSC, ILL, pc, pc + 8);
        f.exc = id_uop_pkg::EXC_ADEF;
        f.badv = pc;
        u0 = uop_ok(SYSC, id_uop_pkg::OP_SYSCALL, 32'd0, pc, pc + 4);
        u1 = uop_ok(ILL, id_uop_pkg::OP_NONE, 32'd0, pc + 4, pc + 8);
        u0.exc = id_uop_pkg::EXC_ADEF;
        u1.exc = id_uop_pkg::EXC_ADEF;
        u0.badv = pc;
        u1.badv = pc;
        add_row("fetch_fault_wins", f, 2'd0, 1'b0, 32'd0, u0, u1);
        table_ready = 1'b1;

        wait (rst_n);
        foreach (table_q[i]) begin
            @(posedge clk);
            fetch       <= table_q[i].fetch;
            plv         <= table_q[i].plv;
            input_valid <= 1'b1;
            @(negedge clk);   // redirect is combinational
            u_checker.check_redirect(name_q[i], table_q[i].redirect);
            @(posedge clk);
            input_valid <= 1'b0;
            @(negedge clk);
            u_checker.check_uops(name_q[i], table_q[i].uop0, table_q[i].uop1);
            u_checker.end_test(name_q[i]);
            @(posedge clk);
            read_en <= table_q[i].read_en;
            @(posedge clk);
            read_en <= 2'b00;
        end

        // pairs with no reads until a bank runs low
        for (int k = 0; k < 7; k++) begin
            @(posedge clk);
            fetch       <= make_fetch(NOP, NOP, BASE + 32'(8 * k), BASE + 32'(8 * k + 8));
            input_valid <= 1'b1;
            @(posedge clk);
            input_valid <= 1'b0;
            @(negedge clk);
            u_checker.check_full("fill_until_full",
                                 ((1 << `ID_BUF_AW) - 2 - k) < `ID_FULL_MARGIN);
        end
        u_checker.end_test("fill_until_full");

        for (int k = 0; k < 4; k++) begin
            @(negedge clk);
            u_checker.check_head_pc("pop_order", BASE + 32'(4 * k), BASE + 32'(4 * k + 4));
            @(posedge clk);
            read_en <= 2'b01;
            @(posedge clk);
            read_en <= 2'b00;
        end
        u_checker.end_test("pop_order");

        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        @(negedge clk);
        u_checker.check_empty("flush_clear");
        u_checker.end_test("flush_clear");

        u_checker.summary();
        if (u_checker.tests_failed == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

    initial begin
        wait (table_ready);
        repeat (table_q.size() * 10 + 100) @(posedge clk);
        $display("timeout: the run did not finish within its cycle budget");
        $display("test failed");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+include
source/id_uop_pkg.sv
source/id_fetch_pkg.sv
source/id_predecoder.sv
source/id_redirect_check.sv
source/id_fetch_buffer.sv
source/id_decoder.sv
source/id_stage.sv
testbench/tb_clock_gen.sv
testbench/tb_id_checker.sv
testbench/tb_id_stage.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f filelist.f --top-module tb_id_stage -o sim_id_stage \
    && ./obj_dir/sim_id_stage | tee /dev/stderr | grep -qx "test passed" \
    && exit 0 \
    || exit 1
